// File: tb/tb_tetris.sv
`timescale 1ns/10ps
`default_nettype none

module tb_tetris;

    localparam int CLK_PERIOD = 100;
    localparam int ROWS = game_pkg::ROWS;
    localparam int COLS = game_pkg::COLS;
    localparam int KEY_WAIT  = game_pkg::STALL_CYCLES + 8;
    localparam int LOCK_WAIT = ROWS + game_pkg::STALL_CYCLES + 8;
    localparam int SCAN_CYCLES = ROWS * COLS + 3;
    localparam int RANDOM_PIECES = 24;
    localparam int MAX_STACK = 40;
    // Worst case per piece is moves and drops to the floor plus lock and a full scan
    localparam int PIECE_CYCLES = (10 + ROWS + 1) * (KEY_WAIT + 2) + LOCK_WAIT + SCAN_CYCLES;
    localparam int RUN_CYCLES = 8 + 2 * SCAN_CYCLES + game_pkg::GRAVITY_TICKS
                                + 40 * (KEY_WAIT + 2 + SCAN_CYCLES)
                                + (RANDOM_PIECES + MAX_STACK + 1) * PIECE_CYCLES;
    localparam int X0 = vga_pkg::BOARD_X0;
    localparam int Y0 = vga_pkg::BOARD_Y0;
    localparam int CELL = vga_pkg::CELL_PX;
    localparam int BACK  = 'h141414;
    localparam int WHITE = 'hffffff;
    localparam int RED   = 'hff1414;

    logic i_clk, i_rst_n, i_start;
    logic [7:0] i_key;
    logic [vga_pkg::PIX_W-1:0] i_x, i_y;
    logic [vga_pkg::COLOR_W-1:0] o_vga_r, o_vga_g, o_vga_b;
    logic o_playing;
    logic [game_pkg::LINES_W-1:0] o_lines;

    // Game model
    int board [ROWS][COLS];
    int p_type, p_rot, p_col, p_row;
    bit p_show, game_over;
    int lines_cnt;
    int cell_c [4];
    int cell_r [4];
    logic [15:0] lfsr;

    tetris_top DUT (
        .i_clk, .i_rst_n, .i_start, .i_key, .i_x, .i_y,
        .o_vga_r, .o_vga_g, .o_vga_b, .o_playing, .o_lines
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    function automatic int code_rgb(input int code);
        case (code)
            0:       return BACK;
            1:       return RED;
            2:       return 'h14ff14;   // Green
            3:       return 'h1414ff;
            4:       return 'h14ffff;   // Cyan
            5:       return 'hff14ff;
            6:       return 'hffff14;   // Yellow
            default: return 'hff6400;
        endcase
    endfunction

    // Fills cell_c and cell_r with the anchor first
    function automatic void piece_cells(input int t, input int rot, input int col, input int row);
        int o [6];
        case (t)
            0: if (rot % 2) o = '{0, -1, -1, 0, -1, 1};
               else         o = '{-1, 0, 0, 1, 1, 1};
            1: if (rot % 2) o = '{-1, -1, -1, 0, 0, 1};
               else         o = '{-1, 1, 0, 1, 1, 0};
            2: case (rot)
                   0:       o = '{-1, 0, 0, 1, 1, 0};
                   1:       o = '{-1, 0, 0, -1, 0, 1};
                   2:       o = '{-1, 0, 0, -1, 1, 0};
                   default: o = '{0, -1, 1, 0, 0, 1};
               endcase
            3: if (rot % 2) o = '{0, -1, 0, 1, 0, 2};
               else         o = '{-1, 0, 1, 0, 2, 0};
            4: case (rot)
                   0:       o = '{-1, 0, 1, 0, 1, 1};
                   1:       o = '{-1, 1, 0, -1, 0, 1};
                   2:       o = '{-1, -1, -1, 0, 1, 0};
                   default: o = '{0, -1, 0, 1, 1, -1};
               endcase
            5: case (rot)
                   0:       o = '{-1, 0, -1, 1, 1, 0};
                   1:       o = '{-1, -1, 0, -1, 0, 1};
                   2:       o = '{-1, 0, 1, 0, 1, -1};
                   default: o = '{0, -1, 0, 1, 1, 1};
               endcase
            default: o = '{0, 1, 1, 0, 1, 1};   // Square
        endcase
        cell_c[0] = col;
        cell_r[0] = row;
        for (int k = 0; k < 3; k++) begin
            cell_c[k + 1] = col + o[2 * k];
            cell_r[k + 1] = row + o[2 * k + 1];
        end
    endfunction

    function automatic bit fits(input int t, input int rot, input int col, input int row);
        piece_cells(t, rot, col, row);
        for (int k = 0; k < 4; k++) begin
            if (cell_c[k] < 0 || cell_c[k] >= COLS || cell_r[k] < 0 || cell_r[k] >= ROWS)
                return 1'b0;
            if (board[cell_r[k]][cell_c[k]] != 0)
                return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic bit try_move(input int dc, input int dr, input int drot);
        if (!fits(p_type, (p_rot + drot) % 4, p_col + dc, p_row + dr))
            return 1'b0;
        p_col = p_col + dc;
        p_row = p_row + dr;
        p_rot = (p_rot + drot) % 4;
        return 1'b1;
    endfunction

    function automatic void lock_and_spawn();
        bit full;
        piece_cells(p_type, p_rot, p_col, p_row);
        for (int k = 0; k < 4; k++)
            board[cell_r[k]][cell_c[k]] = p_type + 1;
        for (int r = 0; r < ROWS; r++) begin
            full = 1'b1;
            for (int c = 0; c < COLS; c++)
                if (board[r][c] == 0) full = 1'b0;
            if (full) begin
                for (int rr = r; rr > 0; rr--)
                    for (int c = 0; c < COLS; c++) board[rr][c] = board[rr - 1][c];
                for (int c = 0; c < COLS; c++) board[0][c] = 0;
                if (lines_cnt < 255) lines_cnt++;
            end
        end
        p_type = (p_type + 1) % 7;   // Fixed cyclic order
        p_col = int'(game_pkg::SPAWN_COL);
        p_row = 0;
        p_rot = 0;
        game_over = !fits(p_type, p_rot, p_col, p_row);
    endfunction

    function automatic int expected_at(input int col, input int row);
        if (p_show) begin
            piece_cells(p_type, p_rot, p_col, p_row);
            for (int k = 0; k < 4; k++)
                if (cell_c[k] == col && cell_r[k] == row) return code_rgb(p_type + 1);
        end
        return code_rgb(board[row][col]);
    endfunction

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic compare(input string what, input int got, input int exp);
        if (got != exp)
            stop_run($sformatf("Error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp));
    endtask

    task automatic press_key(input logic [7:0] code, input int wait_cycles);
        @(posedge i_clk);
        i_key <= code;
        @(posedge i_clk);
        i_key <= 8'h00;
        repeat (wait_cycles) @(posedge i_clk);
    endtask

    // Cell centres of rows 0 to last_row followed by a grid pixel and an outside pixel
    task automatic scan_board(input int last_row);
        int qx [$];
        int qy [$];
        int qe [$];
        int n;
        for (int r = 0; r <= last_row; r++) begin
            for (int c = 0; c < COLS; c++) begin
                qx.push_back(X0 + c * CELL + CELL / 2);
                qy.push_back(Y0 + r * CELL + CELL / 2);
                qe.push_back(expected_at(c, r));
            end
        end
        qx.push_back(X0 + 3 * CELL);
        qy.push_back(Y0 + 25);
        qe.push_back(WHITE);
        qx.push_back(X0 - 10);
        qy.push_back(Y0 + 50);
        qe.push_back(BACK);
        n = qx.size();
        for (int i = 0; i <= n; i++) begin
            @(posedge i_clk);
            if (i < n) begin
                i_x <= vga_pkg::PIX_W'(qx[i]);
                i_y <= vga_pkg::PIX_W'(qy[i]);
            end
            @(negedge i_clk);
            if (i > 0)
                compare($sformatf("o_vga_r/g/b at x=%0d y=%0d", qx[i - 1], qy[i - 1]),
                        int'({o_vga_r, o_vga_g, o_vga_b}), qe[i - 1]);
        end
    endtask

    task automatic walk_to_wall(input int dir);
        bit moved;
        moved = 1'b1;
        while (moved) begin
            moved = try_move(dir, 0, 0);
            press_key((dir > 0) ? game_pkg::KEY_RIGHT : game_pkg::KEY_LEFT, KEY_WAIT);
            scan_board(4);
        end
    endtask

    task automatic place_piece(input bit random_moves);
        int turns, steps, dir;
        bit moved;
        if (random_moves) begin
            turns = rand_bits(2);
            dir = rand_bits(1) ? 1 : -1;
            steps = rand_bits(3);
            repeat (turns) begin
                void'(try_move(0, 0, 1));
                press_key(game_pkg::KEY_UP, KEY_WAIT);
            end
            repeat (steps) begin
                void'(try_move(dir, 0, 0));
                press_key((dir > 0) ? game_pkg::KEY_RIGHT : game_pkg::KEY_LEFT, KEY_WAIT);
            end
        end
        moved = 1'b1;
        while (moved) begin
            moved = try_move(0, 1, 0);   // Blocked drop locks
            press_key(game_pkg::KEY_DOWN, moved ? KEY_WAIT : LOCK_WAIT);
        end
        lock_and_spawn();
        @(negedge i_clk);
        compare("o_lines", int'(o_lines), lines_cnt);
        compare("o_playing", int'(o_playing), int'(!game_over));
        scan_board(ROWS - 1);
    endtask

    initial begin
        #(2 * RUN_CYCLES * CLK_PERIOD);
        stop_run($sformatf("Error at %0d ns: timeout, the run did not finish", $time));
    end

    initial begin
        time t_start;
        bit fell;
        int stacked;
        i_rst_n = 1'b0;
        i_start = 1'b0;
        i_key = 8'h00;
        i_x = '0;
        i_y = '0;
        lfsr = 16'd63110;
        for (int r = 0; r < ROWS; r++)
            for (int c = 0; c < COLS; c++) board[r][c] = 0;
        p_show = 1'b0;
        game_over = 1'b0;
        lines_cnt = 0;
        repeat (3) @(posedge i_clk);
        @(negedge i_clk);
        compare("o_vga_r/g/b in reset", int'({o_vga_r, o_vga_g, o_vga_b}), 0);
        @(posedge i_clk);
        i_rst_n <= 1'b1;

        @(negedge i_clk);
        compare("o_playing", int'(o_playing), 0);
        compare("o_lines", int'(o_lines), 0);
        scan_board(ROWS - 1);

        // Start and first piece
        @(posedge i_clk);
        i_start <= 1'b1;
        t_start = $time;
        @(posedge i_clk);
        i_start <= 1'b0;
        p_show = 1'b1;
        p_type = 0;
        p_col = int'(game_pkg::SPAWN_COL);
        p_row = 0;
        p_rot = 0;
        repeat (KEY_WAIT) @(posedge i_clk);
        @(negedge i_clk);
        compare("o_playing", int'(o_playing), 1);
        scan_board(4);

        // Watch a cell that only the fallen S covers
        @(posedge i_clk);
        i_x <= vga_pkg::PIX_W'(X0 + 5 * CELL + CELL / 2);
        i_y <= vga_pkg::PIX_W'(Y0 + 2 * CELL + CELL / 2);
        fell = 1'b0;
        while (!fell) begin
            @(negedge i_clk);
            fell = (int'({o_vga_r, o_vga_g, o_vga_b}) == RED);
            if (!fell && ($time - t_start) >
                (game_pkg::GRAVITY_TICKS + game_pkg::STALL_CYCLES + 8) * CLK_PERIOD)
                stop_run($sformatf("Error at %0d ns: first piece did not fall by gravity", $time));
        end
        void'(try_move(0, 1, 0));
        scan_board(4);

        walk_to_wall(-1);
        walk_to_wall(1);
        repeat (4) begin
            void'(try_move(0, 0, 1));
            press_key(game_pkg::KEY_UP, KEY_WAIT);
            scan_board(4);
        end

        for (int i = 0; i < RANDOM_PIECES && !game_over; i++)
            place_piece(1'b1);

        stacked = 0;
        while (!game_over && stacked < MAX_STACK) begin
            place_piece(1'b0);
            stacked++;
        end
        if (!game_over)
            stop_run($sformatf("Error at %0d ns: stacking never blocked the spawn", $time));

        // Keys after game over change nothing
        press_key(game_pkg::KEY_LEFT, KEY_WAIT);
        press_key(game_pkg::KEY_DOWN, LOCK_WAIT);
        @(negedge i_clk);
        compare("o_playing", int'(o_playing), 0);
        compare("o_lines", int'(o_lines), lines_cnt);
        scan_board(ROWS - 1);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/game_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module game_fsm (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_start,
    input  game_pkg::move_e             i_move,
    input  logic                        i_blocked,
    input  logic                        i_clear_done,
    output logic [game_pkg::COL_W-1:0]  o_piece_col,
    output logic [game_pkg::ROW_W-1:0]  o_piece_row,
    output game_pkg::piece_e            o_piece_type,
    output logic [1:0]                  o_piece_rot,
    output logic [game_pkg::COL_W-1:0]  o_cand_col,
    output logic [game_pkg::ROW_W-1:0]  o_cand_row,
    output logic [1:0]                  o_cand_rot,
    output logic                        o_lock,
    output logic                        o_clear_board,
    output logic                        o_playing
);

    game_pkg::state_e state;
    logic [$clog2(game_pkg::GRAVITY_TICKS)-1:0] grav_cnt;
    logic [$clog2(game_pkg::STALL_CYCLES)-1:0]  stall_cnt;
    logic grav_due;

    assign grav_due  = (grav_cnt == game_pkg::GRAVITY_TICKS - 1);
    assign o_playing = (state != game_pkg::S_IDLE);

    // Candidate position that the second shape decoder checks
    always_comb begin
        o_cand_col = o_piece_col;
        o_cand_row = o_piece_row;
        o_cand_rot = o_piece_rot;
        if (state == game_pkg::S_WAIT) begin
            case (i_move)
                game_pkg::MV_LEFT:   o_cand_col = o_piece_col - 1'b1;
                game_pkg::MV_RIGHT:  o_cand_col = o_piece_col + 1'b1;
                game_pkg::MV_ROTATE: o_cand_rot = o_piece_rot + 1'b1;
                game_pkg::MV_DOWN:   o_cand_row = o_piece_row + 1'b1;
                default:             o_cand_row = o_piece_row + grav_due;
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state         <= game_pkg::S_IDLE;
            o_piece_col   <= game_pkg::SPAWN_COL;
            o_piece_row   <= game_pkg::HIDE_ROW;
            o_piece_type  <= game_pkg::PC_S;
            o_piece_rot   <= 2'd0;
            grav_cnt      <= '0;
            stall_cnt     <= '0;
            o_lock        <= 1'b0;
            o_clear_board <= 1'b0;
        end else begin
            o_lock        <= 1'b0;
            o_clear_board <= 1'b0;
            case (state)
                game_pkg::S_IDLE: if (i_start) begin
                    o_clear_board <= 1'b1;
                    o_piece_type  <= game_pkg::PC_S;
                    o_piece_col   <= game_pkg::SPAWN_COL;
                    o_piece_row   <= '0;
                    o_piece_rot   <= 2'd0;
                    grav_cnt      <= '0;
                    state         <= game_pkg::S_STALL;
                end
                game_pkg::S_WAIT: begin
                    if (i_move != game_pkg::MV_NONE) begin
                        if (!i_blocked) begin
                            o_piece_col <= o_cand_col;
                            o_piece_row <= o_cand_row;
                            o_piece_rot <= o_cand_rot;
                            state       <= game_pkg::S_STALL;
                            if (i_move == game_pkg::MV_DOWN)
                                grav_cnt <= '0;
                        end else if (i_move == game_pkg::MV_DOWN) begin
                            o_lock <= 1'b1;
                            state  <= game_pkg::S_FALL;
                        end
                    end else if (grav_due) begin
                        grav_cnt <= '0;
                        if (!i_blocked) begin
                            o_piece_row <= o_cand_row;
                        end else begin
                            o_lock <= 1'b1;
                            state  <= game_pkg::S_FALL;
                        end
                    end else begin
                        grav_cnt <= grav_cnt + 1'b1;
                    end
                end
                game_pkg::S_STALL: begin
                    if (stall_cnt == game_pkg::STALL_CYCLES - 1) begin
                        stall_cnt <= '0;
                        // Only a fresh spawn can be blocked here
                        state <= i_blocked ? game_pkg::S_IDLE : game_pkg::S_WAIT;
                    end else begin
                        stall_cnt <= stall_cnt + 1'b1;
                    end
                end
                game_pkg::S_FALL: state <= game_pkg::S_CLEAR;
                game_pkg::S_CLEAR: if (i_clear_done) begin
                    o_piece_type <= (o_piece_type == game_pkg::PC_O) ? game_pkg::PC_S :
                                    game_pkg::piece_e'(o_piece_type + 1'b1);
                    o_piece_col  <= game_pkg::SPAWN_COL;
                    o_piece_row  <= '0;
                    o_piece_rot  <= 2'd0;
                    grav_cnt     <= '0;
                    state        <= game_pkg::S_STALL;
                end
                default: state <= game_pkg::S_IDLE;
            endcase
        end
    end

    a_lock_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_lock |=> !o_lock);

    a_lock_in_fall: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_lock |-> state == game_pkg::S_FALL);

endmodule

`default_nettype wire

// File: verilog/game_pkg.sv
`default_nettype none

package game_pkg;

    // Board geometry
    localparam int COLS  = 10;
    localparam int ROWS  = 20;
    localparam int COL_W = 5;   // Room for wrapped offsets
    localparam int ROW_W = 5;

    localparam logic [COL_W-1:0] SPAWN_COL = 5'd4;
    localparam logic [ROW_W-1:0] HIDE_ROW  = 5'd24;   // Parks the piece off the board before start

    // Timing in clock cycles
    localparam int GRAVITY_TICKS = 4096;
    localparam int STALL_CYCLES  = 16;

    localparam int CODE_W  = 3;   // 0 is empty, type t stored as t+1
    localparam int LINES_W = 8;

    // Keyboard scan codes
    localparam logic [7:0] KEY_UP    = 8'h75;
    localparam logic [7:0] KEY_DOWN  = 8'h72;
    localparam logic [7:0] KEY_LEFT  = 8'h6b;
    localparam logic [7:0] KEY_RIGHT = 8'h74;

    typedef enum logic [2:0] {S_IDLE, S_WAIT, S_STALL, S_FALL, S_CLEAR} state_e;

    typedef enum logic [2:0] {MV_NONE, MV_LEFT, MV_RIGHT, MV_ROTATE, MV_DOWN} move_e;

    typedef enum logic [2:0] {PC_S, PC_Z, PC_T, PC_I, PC_J, PC_L, PC_O} piece_e;

endpackage

`default_nettype wire

// File: verilog/key_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module key_decoder (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic [7:0]       i_key,
    output game_pkg::move_e  o_move
);

    logic [7:0] key_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            key_q  <= 8'h00;
            o_move <= game_pkg::MV_NONE;
        end else begin
            key_q <= i_key;
            case (key_q)
                game_pkg::KEY_UP:    o_move <= game_pkg::MV_ROTATE;
                game_pkg::KEY_DOWN:  o_move <= game_pkg::MV_DOWN;
                game_pkg::KEY_LEFT:  o_move <= game_pkg::MV_LEFT;
                game_pkg::KEY_RIGHT: o_move <= game_pkg::MV_RIGHT;
                default:             o_move <= game_pkg::MV_NONE;
            endcase
        end
    end

    a_move_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_move inside {game_pkg::MV_NONE, game_pkg::MV_LEFT, game_pkg::MV_RIGHT,
                       game_pkg::MV_ROTATE, game_pkg::MV_DOWN});

endmodule

`default_nettype wire

// File: verilog/piece_shape.sv
`timescale 1ns/10ps
`default_nettype none

module piece_shape (
    input  logic [game_pkg::COL_W-1:0]       i_col,
    input  logic [game_pkg::ROW_W-1:0]       i_row,
    input  game_pkg::piece_e                 i_type,
    input  logic [1:0]                       i_rot,
    output logic [3:0][game_pkg::COL_W-1:0]  o_cell_col,
    output logic [3:0][game_pkg::ROW_W-1:0]  o_cell_row
);

    int ofs [3][2];   // (dx, dy) of cells 1 to 3 around the anchor

    always_comb begin
        case (i_type)
            game_pkg::PC_S:
                if (i_rot[0]) ofs = '{'{0, -1}, '{-1, 0}, '{-1, 1}};
                else          ofs = '{'{-1, 0}, '{0, 1}, '{1, 1}};
            game_pkg::PC_Z:
                if (i_rot[0]) ofs = '{'{-1, -1}, '{-1, 0}, '{0, 1}};
                else          ofs = '{'{-1, 1}, '{0, 1}, '{1, 0}};
            game_pkg::PC_T:
                case (i_rot)
                    2'd0:    ofs = '{'{-1, 0}, '{0, 1}, '{1, 0}};
                    2'd1:    ofs = '{'{-1, 0}, '{0, -1}, '{0, 1}};
                    2'd2:    ofs = '{'{-1, 0}, '{0, -1}, '{1, 0}};
                    default: ofs = '{'{0, -1}, '{1, 0}, '{0, 1}};
                endcase
            game_pkg::PC_I:
                if (i_rot[0]) ofs = '{'{0, -1}, '{0, 1}, '{0, 2}};
                else          ofs = '{'{-1, 0}, '{1, 0}, '{2, 0}};
            game_pkg::PC_J:
                case (i_rot)
                    2'd0:    ofs = '{'{-1, 0}, '{1, 0}, '{1, 1}};
                    2'd1:    ofs = '{'{-1, 1}, '{0, -1}, '{0, 1}};
                    2'd2:    ofs = '{'{-1, -1}, '{-1, 0}, '{1, 0}};
                    default: ofs = '{'{0, -1}, '{0, 1}, '{1, -1}};
                endcase
            game_pkg::PC_L:
                case (i_rot)
                    2'd0:    ofs = '{'{-1, 0}, '{-1, 1}, '{1, 0}};
                    2'd1:    ofs = '{'{-1, -1}, '{0, -1}, '{0, 1}};
                    2'd2:    ofs = '{'{-1, 0}, '{1, 0}, '{1, -1}};
                    default: ofs = '{'{0, -1}, '{0, 1}, '{1, 1}};
                endcase
            default: ofs = '{'{0, 1}, '{1, 0}, '{1, 1}};   // O has one orientation
        endcase

        o_cell_col[0] = i_col;
        o_cell_row[0] = i_row;
        // Sums wrap modulo 32, off-board values are caught by the collision test
        for (int k = 0; k < 3; k++) begin
            o_cell_col[k + 1] = i_col + ofs[k][0][game_pkg::COL_W-1:0];
            o_cell_row[k + 1] = i_row + ofs[k][1][game_pkg::ROW_W-1:0];
        end
    end

endmodule

`default_nettype wire

// File: verilog/pixel_render.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_render (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic [vga_pkg::PIX_W-1:0]           i_x,
    input  logic [vga_pkg::PIX_W-1:0]           i_y,
    input  logic [game_pkg::CODE_W-1:0]         i_cell_code,
    input  logic [3:0][game_pkg::COL_W-1:0]     i_piece_col,
    input  logic [3:0][game_pkg::ROW_W-1:0]     i_piece_row,
    input  game_pkg::piece_e                    i_piece_type,
    output logic [game_pkg::COL_W-1:0]          o_pix_col,
    output logic [game_pkg::ROW_W-1:0]          o_pix_row,
    output logic [vga_pkg::COLOR_W-1:0]         o_vga_r,
    output logic [vga_pkg::COLOR_W-1:0]         o_vga_g,
    output logic [vga_pkg::COLOR_W-1:0]         o_vga_b
);

    logic [vga_pkg::PIX_W-1:0]     dx, dy;
    logic [vga_pkg::PIX_W-1:0]     cell_x, cell_y;
    logic [game_pkg::CODE_W-1:0]   piece_code;
    logic [3*vga_pkg::COLOR_W-1:0] rgb;
    logic in_area, on_grid, in_piece;

    assign dx     = i_x - vga_pkg::BOARD_X0;
    assign dy     = i_y - vga_pkg::BOARD_Y0;
    assign cell_x = dx / vga_pkg::CELL_PX;
    assign cell_y = dy / vga_pkg::CELL_PX;
    assign o_pix_col = cell_x[game_pkg::COL_W-1:0];
    assign o_pix_row = cell_y[game_pkg::ROW_W-1:0];

    // Right and bottom edges carry the closing grid line
    assign in_area = (i_x >= vga_pkg::BOARD_X0) && (dx <= game_pkg::COLS * vga_pkg::CELL_PX) &&
                     (i_y >= vga_pkg::BOARD_Y0) && (dy <= game_pkg::ROWS * vga_pkg::CELL_PX);
    assign on_grid = (dx % vga_pkg::CELL_PX == 0) || (dy % vga_pkg::CELL_PX == 0);
    assign piece_code = i_piece_type + 1'b1;

    always_comb begin
        in_piece = 1'b0;
        for (int k = 0; k < 4; k++) begin
            if (i_piece_col[k] == o_pix_col && i_piece_row[k] == o_pix_row)
                in_piece = 1'b1;
        end
        if (!in_area)      rgb = vga_pkg::BACK_RGB;
        else if (on_grid)  rgb = vga_pkg::GRID_RGB;
        else if (in_piece) rgb = vga_pkg::PALETTE[piece_code];
        else               rgb = vga_pkg::PALETTE[i_cell_code];
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            {o_vga_r, o_vga_g, o_vga_b} <= '0;
        else
            {o_vga_r, o_vga_g, o_vga_b} <= rgb;
    end

endmodule

`default_nettype wire

// File: verilog/playfield.sv
`timescale 1ns/10ps
`default_nettype none

module playfield (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic                                i_clear_board,
    input  logic                                i_lock,
    input  game_pkg::piece_e                    i_type,
    input  logic [3:0][game_pkg::COL_W-1:0]     i_lock_col,
    input  logic [3:0][game_pkg::ROW_W-1:0]     i_lock_row,
    input  logic [3:0][game_pkg::COL_W-1:0]     i_cand_col,
    input  logic [3:0][game_pkg::ROW_W-1:0]     i_cand_row,
    input  logic [game_pkg::COL_W-1:0]          i_pix_col,
    input  logic [game_pkg::ROW_W-1:0]          i_pix_row,
    output logic                                o_blocked,
    output logic                                o_clear_done,
    output logic [game_pkg::CODE_W-1:0]         o_pix_code,
    output logic [game_pkg::LINES_W-1:0]        o_lines
);

    logic [game_pkg::COLS-1:0][game_pkg::CODE_W-1:0] board [game_pkg::ROWS];
    logic [game_pkg::ROW_W-1:0] scan_row;
    logic scanning;
    logic row_full;

    function automatic logic in_board(input logic [game_pkg::COL_W-1:0] col,
                                      input logic [game_pkg::ROW_W-1:0] row);
        return (col < game_pkg::COLS) && (row < game_pkg::ROWS);
    endfunction

    always_comb begin
        o_blocked = 1'b0;
        for (int k = 0; k < 4; k++) begin
            if (!in_board(i_cand_col[k], i_cand_row[k]))
                o_blocked = 1'b1;
            else if (board[i_cand_row[k]][i_cand_col[k]] != '0)
                o_blocked = 1'b1;
        end
    end

    always_comb begin
        row_full = 1'b1;
        for (int c = 0; c < game_pkg::COLS; c++) begin
            if (board[scan_row][c] == '0)
                row_full = 1'b0;
        end
    end

    assign o_pix_code   = in_board(i_pix_col, i_pix_row) ? board[i_pix_row][i_pix_col] : '0;
    assign o_clear_done = scanning && (scan_row == game_pkg::ROWS - 1);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int r = 0; r < game_pkg::ROWS; r++)
                board[r] <= '0;
            scanning <= 1'b0;
            scan_row <= '0;
            o_lines  <= '0;
        end else if (i_clear_board) begin
            for (int r = 0; r < game_pkg::ROWS; r++)
                board[r] <= '0;
            scanning <= 1'b0;
            scan_row <= '0;
            o_lines  <= '0;
        end else if (i_lock) begin
            for (int k = 0; k < 4; k++)
                board[i_lock_row[k]][i_lock_col[k]] <= i_type + 1'b1;
            scanning <= 1'b1;
        end else if (scanning) begin
            if (row_full) begin
                // Rows above drop by one
                board[0] <= '0;
                for (int r = 1; r < game_pkg::ROWS; r++) begin
                    if (r <= scan_row)
                        board[r] <= board[r-1];
                end
                if (o_lines != '1)
                    o_lines <= o_lines + 1'b1;   // Saturates
            end
            if (scan_row == game_pkg::ROWS - 1) begin
                scanning <= 1'b0;
                scan_row <= '0;
            end else begin
                scan_row <= scan_row + 1'b1;
            end
        end
    end

    a_lock_on_board: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_lock |-> in_board(i_lock_col[0], i_lock_row[0]) && in_board(i_lock_col[1], i_lock_row[1])
                && in_board(i_lock_col[2], i_lock_row[2]) && in_board(i_lock_col[3], i_lock_row[3]));

endmodule

`default_nettype wire

// File: verilog/tetris_top.sv
`timescale 1ns/10ps
`default_nettype none

module tetris_top (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_start,
    input  logic [7:0]                      i_key,
    input  logic [vga_pkg::PIX_W-1:0]       i_x,
    input  logic [vga_pkg::PIX_W-1:0]       i_y,
    output logic [vga_pkg::COLOR_W-1:0]     o_vga_r,
    output logic [vga_pkg::COLOR_W-1:0]     o_vga_g,
    output logic [vga_pkg::COLOR_W-1:0]     o_vga_b,
    output logic                            o_playing,
    output logic [game_pkg::LINES_W-1:0]    o_lines
);

    game_pkg::move_e                 move;
    game_pkg::piece_e                piece_type;
    logic [game_pkg::COL_W-1:0]      piece_col, cand_col, pix_col;
    logic [game_pkg::ROW_W-1:0]      piece_row, cand_row, pix_row;
    logic [1:0]                      piece_rot, cand_rot;
    logic [3:0][game_pkg::COL_W-1:0] act_cell_col, cand_cell_col;
    logic [3:0][game_pkg::ROW_W-1:0] act_cell_row, cand_cell_row;
    logic [game_pkg::CODE_W-1:0]     pix_code;
    logic lock, clear_board, clear_done, blocked;

    key_decoder u_key (.i_clk, .i_rst_n, .i_key, .o_move(move));

    game_fsm u_fsm (
        .i_clk, .i_rst_n, .i_start, .i_move(move), .i_blocked(blocked),
        .i_clear_done(clear_done), .o_piece_col(piece_col), .o_piece_row(piece_row),
        .o_piece_type(piece_type), .o_piece_rot(piece_rot), .o_cand_col(cand_col),
        .o_cand_row(cand_row), .o_cand_rot(cand_rot), .o_lock(lock),
        .o_clear_board(clear_board), .o_playing
    );

    piece_shape u_shape_act (
        .i_col(piece_col), .i_row(piece_row), .i_type(piece_type), .i_rot(piece_rot),
        .o_cell_col(act_cell_col), .o_cell_row(act_cell_row)
    );

    piece_shape u_shape_cand (
        .i_col(cand_col), .i_row(cand_row), .i_type(piece_type), .i_rot(cand_rot),
        .o_cell_col(cand_cell_col), .o_cell_row(cand_cell_row)
    );

    playfield u_field (
        .i_clk, .i_rst_n, .i_clear_board(clear_board), .i_lock(lock), .i_type(piece_type),
        .i_lock_col(act_cell_col), .i_lock_row(act_cell_row), .i_cand_col(cand_cell_col),
        .i_cand_row(cand_cell_row), .i_pix_col(pix_col), .i_pix_row(pix_row),
        .o_blocked(blocked), .o_clear_done(clear_done), .o_pix_code(pix_code), .o_lines
    );

    pixel_render u_render (
        .i_clk, .i_rst_n, .i_x, .i_y, .i_cell_code(pix_code), .i_piece_col(act_cell_col),
        .i_piece_row(act_cell_row), .i_piece_type(piece_type), .o_pix_col(pix_col),
        .o_pix_row(pix_row), .o_vga_r, .o_vga_g, .o_vga_b
    );

endmodule

`default_nettype wire

// File: verilog/vga_pkg.sv
`default_nettype none

package vga_pkg;

    localparam int PIX_W   = 10;
    localparam int COLOR_W = 8;

    // Board placement on screen
    localparam logic [PIX_W-1:0] BOARD_X0 = 10'd220;
    localparam logic [PIX_W-1:0] BOARD_Y0 = 10'd40;
    localparam logic [PIX_W-1:0] CELL_PX  = 10'd20;

    localparam logic [3*COLOR_W-1:0] BACK_RGB = {8'd20, 8'd20, 8'd20};
    localparam logic [3*COLOR_W-1:0] GRID_RGB = {8'd255, 8'd255, 8'd255};

    // Indexed by cell code
    localparam logic [3*COLOR_W-1:0] PALETTE [8] = '{
        {8'd20, 8'd20, 8'd20},      // Empty
        {8'd255, 8'd20, 8'd20},
        {8'd20, 8'd255, 8'd20},
        {8'd20, 8'd20, 8'd255},
        {8'd20, 8'd255, 8'd255},
        {8'd255, 8'd20, 8'd255},
        {8'd255, 8'd255, 8'd20},
        {8'd255, 8'd100, 8'd0}      // Orange
    };

endpackage

`default_nettype wire

// File: vlog.f
verilog/game_pkg.sv
verilog/vga_pkg.sv
verilog/key_decoder.sv
verilog/piece_shape.sv
verilog/game_fsm.sv
verilog/playfield.sv
verilog/pixel_render.sv
verilog/tetris_top.sv
tb/tb_tetris.sv
